// File: all.f
verilog/button_event_pkg.sv
verilog/apb_map_pkg.sv
verilog/debounce_timer.sv
verilog/edge_detector_debounce.sv
verilog/button_event_source.sv
verilog/event_fifo.sv
verilog/button_apb_regs.sv
verilog/button_input_top.sv
tb/button_input_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the button input testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=button_input_tb
LOG=sim.log

verilator --binary -j 0 --timescale 1ns/1ns -Wno-fatal --top-module "$TOP" -f all.f
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "Result: FAIL"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
echo "Result: PASS"
exit 0

// File: tb/button_input_tb.sv
/* Table-driven testbench for the push-button input block,
   with APB master, bounce generator and checker */
`default_nettype none

module button_input_tb;

   timeunit 1ns;
   timeprecision 1ns;

   localparam int NUM_BUTTONS = 4;
   localparam int HOLD_CYCLES = 16;
   localparam int FIFO_DEPTH  = 8;
   localparam int CLK_PERIOD  = 20;
   localparam int NUM_ROWS    = 5;
   localparam int SETTLE      = NUM_BUTTONS + 4 + HOLD_CYCLES;  // Wait after each press
   localparam int HOLD_LEN    = HOLD_CYCLES + 8;               // Held past the lockout
   localparam int BOUNCE_MAX  = 12;                            // Two glitches, 3 + 3 each
   localparam int APB_LEN     = 3;                             // Setup, access, idle

   localparam logic [apb_map_pkg::ADDR_W-1:0] UNMAPPED_OFS = 5'h10;

   // One stimulus row
   typedef struct
   {
      string                  name;
      logic                   en;         // CTRL enable for the row
      logic [NUM_BUTTONS-1:0] mask;       // Buttons pressed
      logic                   bounce;
      logic                   stagger;    // One button per cycle, lowest first
      int                     presses;
      logic                   read_back;
      int                     events;
      logic [47:0]            idx_list;   // Index of event k in nibble k
      int                     drops;
   } row_t;

   logic                           clk;
   logic                           reset;
   logic [NUM_BUTTONS-1:0]         buttons;
   logic                           psel;
   logic                           penable;
   logic                           pwrite;
   logic [apb_map_pkg::ADDR_W-1:0] paddr;
   logic [apb_map_pkg::DATA_W-1:0] pwdata;
   logic [apb_map_pkg::DATA_W-1:0] prdata;
   logic                           pready;
   logic                           pslverr;

   row_t rows [NUM_ROWS];
   int   cycles     = 0;
   int   limit      = 0;
   int   last_stamp = 0;     // Stamp of the previous popped event

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   button_input_top #(
      .NUM_BUTTONS (NUM_BUTTONS),
      .HOLD_CYCLES (HOLD_CYCLES),
      .FIFO_DEPTH  (FIFO_DEPTH)
   ) button_input_top_inst (
      .clk     (clk),
      .reset   (reset),
      .buttons (buttons),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   // Watchdog
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles > limit)
      begin
         $display("Timeout: the run went past %0d cycles without finishing", limit);
         $display("Simulation failed");
         $fatal(1, "timeout");
      end
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////
   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
         $display("Simulation failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic apb_write(input logic [apb_map_pkg::ADDR_W-1:0] addr,
                            input logic [31:0] data);
      @(negedge clk);
      psel    = 1'b1;          // Setup
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;          // Access, taken at next rising edge
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input string name, input logic [apb_map_pkg::ADDR_W-1:0] addr,
                           output logic [31:0] data, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      #(CLK_PERIOD / 4);       // Mid access cycle, before the pop edge
      data = prdata;
      err  = pslverr;
      check({name, " pready"}, 32'd1, 32'(pready));
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // Optional bounce, optional stagger, long hold, release, settle
   task automatic press(input logic [NUM_BUTTONS-1:0] mask, input logic bounce,
                        input logic stagger);
      int width;
      @(negedge clk);
      if (bounce)
      begin
         repeat (2)
         begin
            width   = 1 + ($urandom % 3);   // Well inside the lockout
            buttons = mask;
            wait_cycles(width);
            width   = 1 + ($urandom % 3);
            buttons = '0;
            wait_cycles(width);
         end
      end
      if (stagger)
      begin
         for (int i = 0; i < NUM_BUTTONS; i++)
         begin
            buttons = buttons | (mask & (NUM_BUTTONS'(1) << i));
            wait_cycles(1);
         end
      end
      buttons = mask;
      wait_cycles(HOLD_LEN);
      buttons = '0;
      wait_cycles(SETTLE);
   endtask

   // Status word from the register map
   function automatic logic [31:0] expected_status(input int fill);
      logic [31:0] word;
      word = '0;
      word[apb_map_pkg::STAT_EMPTY_BIT]      = (fill == 0);
      word[apb_map_pkg::STAT_FULL_BIT]       = (fill == FIFO_DEPTH);
      word[apb_map_pkg::STAT_COUNT_LSB +: 8] = 8'(fill);
      return word;
   endfunction

   task automatic set_row(input int r, input string name, input logic en,
                          input logic [NUM_BUTTONS-1:0] mask, input logic bounce,
                          input logic stagger, input int presses, input logic read_back,
                          input int events, input logic [47:0] idx_list, input int drops);
      rows[r].name      = name;
      rows[r].en        = en;
      rows[r].mask      = mask;
      rows[r].bounce    = bounce;
      rows[r].stagger   = stagger;
      rows[r].presses   = presses;
      rows[r].read_back = read_back;
      rows[r].events    = events;
      rows[r].idx_list  = idx_list;
      rows[r].drops     = drops;
   endtask

   //////////////////////////////
   // Stimulus table
   //////////////////////////////
   task automatic load_rows();
      set_row(0, "disabled",      1'b0, 4'b0010, 1'b0, 1'b0, 1, 1'b1, 0,  48'h0, 0);
      set_row(1, "clean_press",   1'b1, 4'b0100, 1'b0, 1'b0, 1, 1'b1, 1,  48'h2, 0);
      set_row(2, "bounce_hold",   1'b1, 4'b0001, 1'b1, 1'b0, 2, 1'b1, 2,  48'h0, 0);
      set_row(3, "simultaneous",  1'b1, 4'b1101, 1'b0, 1'b0, 1, 1'b1, 3,  48'h320, 0);
      // Round 4 merges into the presses that round 3 left pending
      set_row(4, "back_pressure", 1'b1, 4'b1111, 1'b0, 1'b1, 4, 1'b1, 12,
              48'h3210_3210_3210, 4);
   endtask

   function automatic int run_limit();
      int total;
      total = 2 + 4 * APB_LEN;   // Reset and post-reset reads
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         total += rows[r].presses * (BOUNCE_MAX + NUM_BUTTONS + HOLD_LEN + SETTLE + 1);
         total += (rows[r].events + 8) * APB_LEN;
      end
      return 2 * total;
   endfunction

   task automatic apply_row(input int r);
      logic [31:0]              data;
      logic                     err;
      int                       fill;
      button_event_pkg::event_t ev;
      string                    name;
      name = rows[r].name;
      apb_write(apb_map_pkg::CTRL_OFS, 32'(rows[r].en));
      apb_read(name, apb_map_pkg::CTRL_OFS, data, err);
      check({name, " ctrl"}, 32'(rows[r].en), data);
      repeat (rows[r].presses)
      begin
         press(rows[r].mask, rows[r].bounce, rows[r].stagger);
      end
      // FIFO holds up to its depth, rest waits as pending
      fill = (rows[r].events > FIFO_DEPTH) ? FIFO_DEPTH : rows[r].events;
      apb_read(name, apb_map_pkg::STATUS_OFS, data, err);
      check({name, " status"}, expected_status(fill), data);
      apb_read(name, apb_map_pkg::DROPS_OFS, data, err);
      check({name, " drops"}, 32'(rows[r].drops), data);
      if (rows[r].read_back)
      begin
         for (int k = 0; k < rows[r].events; k++)
         begin
            apb_read(name, apb_map_pkg::EVENT_OFS, data, err);
            ev = data[button_event_pkg::EVENT_W-1:0];
            check($sformatf("%s event %0d pslverr", name, k), 32'd0, 32'(err));
            check($sformatf("%s event %0d index", name, k),
                  32'(rows[r].idx_list[4*k +: 4]), 32'(ev.idx));
            // One issue per cycle, so each stamp is later than the last
            check($sformatf("%s event %0d stamp order", name, k), 32'd1,
                  32'(ev.stamp > last_stamp));
            last_stamp = ev.stamp;
         end
         apb_read(name, apb_map_pkg::STATUS_OFS, data, err);
         check({name, " drained"}, expected_status(0), data);
      end
      apb_write(apb_map_pkg::DROPS_OFS, 32'h0);     // Any write clears
      apb_read(name, apb_map_pkg::DROPS_OFS, data, err);
      check({name, " drops cleared"}, 32'd0, data);
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////
   initial
   begin
      logic [31:0] data;
      logic        err;
      reset   = 1'b0;
      buttons = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      void'($urandom(83));
      load_rows();
      limit = run_limit();
      repeat (2) @(negedge clk);
      reset = 1'b1;

      apb_read("reset", apb_map_pkg::CTRL_OFS, data, err);
      check("reset ctrl", 32'd0, data);
      apb_read("reset", apb_map_pkg::STATUS_OFS, data, err);
      check("reset status", expected_status(0), data);
      apb_read("reset", apb_map_pkg::EVENT_OFS, data, err);   // Empty pop is an error
      check("reset event data", 32'd0, data);
      check("reset event pslverr", 32'd1, 32'(err));
      apb_read("reset", UNMAPPED_OFS, data, err);
      check("unmapped data", 32'd0, data);
      check("unmapped pslverr", 32'd0, 32'(err));

      for (int r = 0; r < NUM_ROWS; r++)
      begin
         apply_row(r);
      end
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/apb_map_pkg.sv
/* APB register offsets, control and status bit positions, error response */
`default_nettype none

package apb_map_pkg;

   localparam int ADDR_W = 5;   // Byte address, four words used
   localparam int DATA_W = 32;

   // Register offsets
   localparam logic [ADDR_W-1:0] CTRL_OFS   = 5'h00;  // Enable, read/write
   localparam logic [ADDR_W-1:0] STATUS_OFS = 5'h04;  // Read only
   localparam logic [ADDR_W-1:0] EVENT_OFS  = 5'h08;  // Read pops FIFO head
   localparam logic [ADDR_W-1:0] DROPS_OFS  = 5'h0C;  // Write clears

   // Bit positions
   localparam int CTRL_EN_BIT    = 0;
   localparam int STAT_EMPTY_BIT = 0;
   localparam int STAT_FULL_BIT  = 1;
   localparam int STAT_COUNT_LSB = 8;   // Count occupies bits 8 and up

   localparam int DROPS_W = 16;        // Saturating drop counter

   // Data returned on an EVENT read of an empty FIFO
   localparam logic [DATA_W-1:0] ERR_RDATA = '0;

endpackage

`default_nettype wire

// File: verilog/button_apb_regs.sv
/* APB register slave with control, status,
   event pop and saturating drop counter */
`default_nettype none

module button_apb_regs
#(
   parameter int FIFO_DEPTH = 8
)
(
   input  wire                                clk,
   input  wire                                reset,
   input  wire                                psel,
   input  wire                                penable,
   input  wire                                pwrite,
   input  wire  [apb_map_pkg::ADDR_W-1:0]     paddr,
   input  wire  [apb_map_pkg::DATA_W-1:0]     pwdata,
   output logic [apb_map_pkg::DATA_W-1:0]     prdata,
   output logic                               pready,
   output logic                               pslverr,
   input  button_event_pkg::event_t           head_data,
   input  wire                                empty,
   input  wire                                full,
   input  wire  [$clog2(FIFO_DEPTH):0]        count,
   output logic                               pop,
   input  wire                                drop,
   output logic                               enable
);

   localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

   logic                              wr_access;
   logic                              rd_access;
   logic                              event_rd;
   logic [apb_map_pkg::DROPS_W-1:0]   drops;
   logic [apb_map_pkg::DATA_W-1:0]    status_word;

   assign wr_access = psel && penable && pwrite;     // Access phase only
   assign rd_access = psel && penable && !pwrite;
   assign event_rd  = rd_access && (paddr == apb_map_pkg::EVENT_OFS);

   assign pready  = 1'b1;                            // No wait states
   assign pop     = event_rd && !empty;              // Pops at end of access
   assign pslverr = event_rd && empty;               // Empty read is an error

   //////////////////////////////
   // Control and drop counter
   //////////////////////////////
   always_ff @(posedge clk)
   begin
      if (!reset)
      begin
         enable <= 1'b0;
         drops  <= '0;
      end
      else
      begin
         if (wr_access && (paddr == apb_map_pkg::CTRL_OFS))
            enable <= pwdata[apb_map_pkg::CTRL_EN_BIT];
         if (wr_access && (paddr == apb_map_pkg::DROPS_OFS))
            drops <= '0;                             // Any write clears, wins over drop
         else if (drop && (drops != '1))
            drops <= drops + 1'b1;                   // Saturates at all ones
      end
   end

   // Status word
   always_comb
   begin
      status_word                                    = '0;
      status_word[apb_map_pkg::STAT_EMPTY_BIT]       = empty;
      status_word[apb_map_pkg::STAT_FULL_BIT]        = full;
      status_word[apb_map_pkg::STAT_COUNT_LSB +: CNT_W] = count;
   end

   //////////////////////////////
   // Read mux
   //////////////////////////////
   always_comb
   begin
      unique case (paddr)
         apb_map_pkg::CTRL_OFS:   prdata = (apb_map_pkg::DATA_W)'(enable);
         apb_map_pkg::STATUS_OFS: prdata = status_word;
         apb_map_pkg::EVENT_OFS:  prdata = empty ? apb_map_pkg::ERR_RDATA
                                                 : (apb_map_pkg::DATA_W)'(head_data);
         apb_map_pkg::DROPS_OFS:  prdata = (apb_map_pkg::DATA_W)'(drops);
         default:                 prdata = '0;        // Unmapped reads zero
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/button_event_pkg.sv
/* Event word layout, index and timestamp widths,
   and the press detector state encoding */
`default_nettype none

package button_event_pkg;

   //////////////////////////////
   // Event word
   //////////////////////////////
   localparam int BTN_IDX_W = 4;                    // Up to 16 buttons
   localparam int STAMP_W   = 12;                   // Free-running timestamp bits
   localparam int EVENT_W   = BTN_IDX_W + STAMP_W;  // One 16-bit word

   // Index in the upper bits, stamp below
   typedef struct packed
   {
      logic [BTN_IDX_W-1:0] idx;    // Button that was pressed
      logic [STAMP_W-1:0]   stamp;  // Counter value at issue time
   } event_t;

   //////////////////////////////
   // Detector states
   //////////////////////////////
   typedef enum logic [1:0]
   {
      not_detected    = 2'b00,  // Idle, watching for a rising input
      edge_detected   = 2'b01,  // Single pulse cycle
      lockout         = 2'b11,  // Input ignored while timer runs
      waiting_release = 2'b10   // Still held after lockout
   } det_state_t;

endpackage

`default_nettype wire

// File: verilog/button_event_source.sv
/* Button synchronizers, per-button detectors, pending set,
   lowest-index arbiter, timestamp counter and drop pulses */
`default_nettype none

module button_event_source
#(
   parameter int NUM_BUTTONS = 4,
   parameter int HOLD_CYCLES = 16
)
(
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          enable,
   input  wire  [NUM_BUTTONS-1:0]       buttons,
   input  wire                          full,
   output logic                         push,
   output button_event_pkg::event_t     push_data,
   output logic                         drop
);

   logic [NUM_BUTTONS-1:0]                  sync1;
   logic [NUM_BUTTONS-1:0]                  sync2;
   logic [NUM_BUTTONS-1:0]                  detect;
   logic [NUM_BUTTONS-1:0]                  pending;
   logic [NUM_BUTTONS-1:0]                  issue_mask;
   logic [button_event_pkg::BTN_IDX_W-1:0]  sel;
   logic [button_event_pkg::STAMP_W-1:0]    stamp;

   //////////////////////////////
   // Two-flop synchronizer
   //////////////////////////////
   always_ff @(posedge clk)
   begin
      if (!reset)
      begin
         sync1 <= '0;
         sync2 <= '0;
      end
      else
      begin
         sync1 <= buttons;
         sync2 <= sync1;
      end
   end

   // One detector per button
   for (genvar g = 0; g < NUM_BUTTONS; g++)
   begin : g_det
      edge_detector_debounce #(
         .HOLD_CYCLES (HOLD_CYCLES)
      ) det_inst (
         .clk      (clk),
         .reset    (reset),
         .enable   (enable),
         .in       (sync2[g]),
         .detected (detect[g])
      );
   end

   // Lowest pending index wins
   always_comb
   begin
      sel = '0;
      for (int i = NUM_BUTTONS - 1; i >= 0; i--)
      begin
         if (pending[i])
         begin
            sel = button_event_pkg::BTN_IDX_W'(i);
         end
      end
   end

   assign push       = (|pending) && !full;           // Never pushes into a full FIFO
   assign issue_mask = push ? (NUM_BUTTONS'(1) << sel) : '0;

   always_comb
   begin
      push_data.idx   = sel;
      push_data.stamp = stamp;     // Stamped at issue time
   end

   //////////////////////////////
   // Pending set, stamp, drops
   //////////////////////////////
   always_ff @(posedge clk)
   begin
      if (!reset)
      begin
         pending <= '0;
         stamp   <= '0;
         drop    <= 1'b0;
      end
      else
      begin
         pending <= (pending & ~issue_mask) | detect;
         stamp   <= stamp + 1'b1;                     // Free running, wraps
         drop    <= |(detect & pending & ~issue_mask); // Press merged into pending
      end
   end

endmodule

`default_nettype wire

// File: verilog/button_input_top.sv
/* Push-button input block, event source to FIFO to APB registers */
`default_nettype none

module button_input_top
#(
   parameter int NUM_BUTTONS = 4,   // 1 to 16
   parameter int HOLD_CYCLES = 16,  // At least NUM_BUTTONS
   parameter int FIFO_DEPTH  = 8    // Power of two
)
(
   input  wire                             clk,
   input  wire                             reset,
   input  wire  [NUM_BUTTONS-1:0]          buttons,
   input  wire                             psel,
   input  wire                             penable,
   input  wire                             pwrite,
   input  wire  [apb_map_pkg::ADDR_W-1:0]  paddr,
   input  wire  [apb_map_pkg::DATA_W-1:0]  pwdata,
   output logic [apb_map_pkg::DATA_W-1:0]  prdata,
   output logic                            pready,
   output logic                            pslverr
);

   button_event_pkg::event_t    push_data;
   button_event_pkg::event_t    head_data;
   logic                        push;
   logic                        pop;
   logic                        drop;
   logic                        enable;
   logic                        empty;
   logic                        full;
   logic [$clog2(FIFO_DEPTH):0] count;

   // Producer
   button_event_source #(
      .NUM_BUTTONS (NUM_BUTTONS),
      .HOLD_CYCLES (HOLD_CYCLES)
   ) source_inst (
      .clk       (clk),
      .reset     (reset),
      .enable    (enable),
      .buttons   (buttons),
      .full      (full),
      .push      (push),
      .push_data (push_data),
      .drop      (drop)
   );

   // Event buffer
   event_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) fifo_inst (
      .clk       (clk),
      .reset     (reset),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .head_data (head_data),
      .empty     (empty),
      .full      (full),
      .count     (count)
   );

   // CPU side
   button_apb_regs #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) regs_inst (
      .clk       (clk),
      .reset     (reset),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .head_data (head_data),
      .empty     (empty),
      .full      (full),
      .count     (count),
      .pop       (pop),
      .drop      (drop),
      .enable    (enable)
   );

endmodule

`default_nettype wire

// File: verilog/debounce_timer.sv
/* Lockout counter, timeout after HOLD_CYCLES enabled cycles */
`default_nettype none

module debounce_timer
#(
   parameter int HOLD_CYCLES = 16
)
(
   input  wire  clk,
   input  wire  reset,
   input  wire  clr,
   input  wire  en,
   output logic timeout
);

   // At least one bit, even for a single-cycle hold
   localparam int CNT_W = (HOLD_CYCLES > 1) ? $clog2(HOLD_CYCLES) : 1;
   localparam logic [CNT_W-1:0] LAST = CNT_W'(HOLD_CYCLES - 1);

   logic [CNT_W-1:0] cnt;

   always_ff @(posedge clk)
   begin
      if (!reset || clr)
      begin
         cnt <= '0;
      end
      else if (en && !timeout)      // Stops at LAST, so timeout stays up
      begin
         cnt <= cnt + 1'b1;
      end
   end

   assign timeout = (cnt == LAST);  // High until the next clear

endmodule

`default_nettype wire

// File: verilog/edge_detector_debounce.sv
/* Four-state press detector with a debounce lockout */
`default_nettype none

module edge_detector_debounce
#(
   parameter int HOLD_CYCLES = 16
)
(
   input  wire  clk,
   input  wire  reset,
   input  wire  enable,
   input  wire  in,
   output logic detected
);

   button_event_pkg::det_state_t state;
   button_event_pkg::det_state_t next_state;

   logic timer_en;
   logic timer_clr;
   logic timeout;

   // Timer only runs in lockout, cleared everywhere else
   assign timer_en  = enable && (state == button_event_pkg::lockout);
   assign timer_clr = (state != button_event_pkg::lockout);

   debounce_timer #(
      .HOLD_CYCLES (HOLD_CYCLES)
   ) timer_inst (
      .clk     (clk),
      .reset   (reset),
      .clr     (timer_clr),
      .en      (timer_en),
      .timeout (timeout)
   );

   //////////////////////////////
   // State register
   //////////////////////////////
   always_ff @(posedge clk)
   begin
      if (!reset)
      begin
         state <= button_event_pkg::not_detected;
      end
      else if (enable)             // Frozen while disabled
      begin
         state <= next_state;
      end
   end

   //////////////////////////////
   // Next state
   //////////////////////////////
   always_comb
   begin
      next_state = state;          // Default hold, lockout relies on it
      unique case (state)
         button_event_pkg::not_detected:
         begin
            if (in)
            begin
               next_state = button_event_pkg::edge_detected;
            end
         end
         button_event_pkg::edge_detected:
         begin
            next_state = button_event_pkg::lockout;
         end
         button_event_pkg::lockout:
         begin
            if (timeout)           // Sample input only once lockout ends
            begin
               next_state = in ? button_event_pkg::waiting_release
                               : button_event_pkg::not_detected;
            end
         end
         button_event_pkg::waiting_release:
         begin
            if (!in)
            begin
               next_state = button_event_pkg::not_detected;
            end
         end
         default:
         begin
            next_state = button_event_pkg::not_detected;
         end
      endcase
   end

   // One-cycle pulse, suppressed while disabled
   assign detected = enable && (state == button_event_pkg::edge_detected);

endmodule

`default_nettype wire

// File: verilog/event_fifo.sv
/* First-word-fall-through event FIFO with occupancy count */
`default_nettype none

module event_fifo
#(
   parameter int FIFO_DEPTH = 8    // Power of two, at least 2
)
(
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          push,
   input  button_event_pkg::event_t     push_data,
   input  wire                          pop,
   output button_event_pkg::event_t     head_data,
   output logic                         empty,
   output logic                         full,
   output logic [$clog2(FIFO_DEPTH):0]  count
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   button_event_pkg::event_t mem [FIFO_DEPTH];   // Storage, no reset

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             wr_en;
   logic             rd_en;

   assign wr_en = push && !full;    // Push while full dropped
   assign rd_en = pop && !empty;    // Pop while empty ignored

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_ptr] <= push_data;
      end
   end

   //////////////////////////////
   // Pointers and occupancy
   //////////////////////////////
   always_ff @(posedge clk)
   begin
      if (!reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

   assign head_data = mem[rd_ptr];    // Head falls through
   assign empty     = (count == '0);
   assign full      = (count == ($clog2(FIFO_DEPTH) + 1)'(FIFO_DEPTH));

endmodule

`default_nettype wire
